/* filelist.f */
+incdir+src
src/logger_pkg.sv
src/memory_macro.sv
src/sync_fifo.sv
src/log_arbiter.sv
src/event_logger_top.sv
testbench/tb_clock_gen.sv
testbench/event_logger_assert.sv
testbench/event_logger_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the event logger testbench with Verilator
# Exit status is nonzero when the simulation fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
	-f filelist.f \
	--top-module event_logger_tb \
	--Mdir obj_dir \
	-o event_logger_sim &&
./obj_dir/event_logger_sim ||
{ echo "event logger simulation failed"; exit 1; }

/* src/event_logger_top.sv */
`include "logger_macros.svh"

module event_logger_top (
	input logic clk,
	input logic reset,

	// Sensor sample channel
	input logic sample_valid,
	output logic sample_ready,
	input logger_pkg::sample_t sample_data,

	// Event code channel
	input logic event_valid,
	output logic event_ready,
	input logger_pkg::event_t event_data,

	// Shared log output
	output logic log_valid,
	input logic log_ready,
	output logger_pkg::log_record_t log_data,

	// Fill level of each FIFO
	output logger_pkg::fifo_status_t status
);

	import logger_pkg::*;

	////////////////////////////////////////////////////////////
	// Front ends

	// FIFO heads and flags toward the arbiter
	sample_t sample_head;
	event_t event_head;
	logic sample_empty;
	logic event_empty;
	logic sample_full;
	logic event_full;
	logic sample_pop;
	logic event_pop;
	logic sample_wr;
	logic event_wr;
	logic [`LOG_LEVEL_BITS-1:0] sample_level;
	logic [`LOG_LEVEL_BITS-1:0] event_level;

	// Accept while there is room
	assign sample_ready = !sample_full;
	assign event_ready = !event_full;

	// Write only on a completed handshake
	assign sample_wr = sample_valid && sample_ready;
	assign event_wr = event_valid && event_ready;

	////////////////////////////////////////////////////////////
	// Channel FIFOs

	sync_fifo #(
		.payload_t(sample_t),
		.DEPTH(`LOG_FIFO_DEPTH)
	) sample_fifo (
		.clk(clk),
		.reset(reset),
		.wr(sample_wr),
		.din(sample_data),
		.rd(sample_pop),
		.dout(sample_head),
		.empty(sample_empty),
		.full(sample_full),
		.rsize(sample_level),
		.wsize(),
		// Gated handshakes keep these low
		.overflow(),
		.underflow()
	);

	sync_fifo #(
		.payload_t(event_t),
		.DEPTH(`LOG_FIFO_DEPTH)
	) event_fifo (
		.clk(clk),
		.reset(reset),
		.wr(event_wr),
		.din(event_data),
		.rd(event_pop),
		.dout(event_head),
		.empty(event_empty),
		.full(event_full),
		.rsize(event_level),
		.wsize(),
		.overflow(),
		.underflow()
	);

	////////////////////////////////////////////////////////////
	// Log port arbitration

	log_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.sample_head(sample_head),
		.sample_empty(sample_empty),
		.sample_pop(sample_pop),
		.event_head(event_head),
		.event_empty(event_empty),
		.event_pop(event_pop),
		.log_valid(log_valid),
		.log_ready(log_ready),
		.log_data(log_data)
	);

	// Status straight from the read-side levels
	assign status.sample_level = sample_level;
	assign status.event_level = event_level;

endmodule

/* src/log_arbiter.sv */
`include "logger_macros.svh"

module log_arbiter (
	input logic clk,
	input logic reset,

	// Sample FIFO head
	input logger_pkg::sample_t sample_head,
	input logic sample_empty,
	output logic sample_pop,

	// Event FIFO head
	input logger_pkg::event_t event_head,
	input logic event_empty,
	output logic event_pop,

	// Shared log port
	output logic log_valid,
	input logic log_ready,
	output logger_pkg::log_record_t log_data
);

	import logger_pkg::*;

	////////////////////////////////////////////////////////////
	// State

	// Source that won the previous grant
	log_source_e last_src;

	// Output register
	logic out_valid;
	log_record_t out_rec;

	// Combinational grant
	logic can_load;
	logic pick_sample;
	logic pick_event;
	log_record_t next_rec;

	////////////////////////////////////////////////////////////
	// Grant

	// Register is free or its record leaves this edge
	assign can_load = !out_valid || log_ready;

	// Sample wins alone, or under contention when events went last
	assign pick_sample = !sample_empty && (event_empty || last_src == SRC_EVENT);

	// Event takes whatever the sample channel did not
	assign pick_event = !event_empty && !pick_sample;

	// Pop the winner on the same edge that loads the register
	assign sample_pop = can_load && pick_sample;
	assign event_pop = can_load && pick_event;

	////////////////////////////////////////////////////////////
	// Record formatting

	always_comb begin
		if (pick_sample) begin
			next_rec.source = SRC_SAMPLE;
			// Sample fills the data field exactly
			next_rec.data = `LOG_DATA_BITS'(sample_head);
		end else begin
			next_rec.source = SRC_EVENT;
			// Event code zero-extended
			next_rec.data = `LOG_DATA_BITS'(event_head.code);
		end
	end

	////////////////////////////////////////////////////////////
	// Control registers

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			// Events count as last served so samples win first
			last_src <= SRC_EVENT;
		end else if (can_load) begin
			// Stays valid only if a new record comes in
			out_valid <= sample_pop || event_pop;
			if (sample_pop) begin
				last_src <= SRC_SAMPLE;
			end else if (event_pop) begin
				last_src <= SRC_EVENT;
			end
		end
	end

	// Payload register, held while the consumer stalls
	always_ff @(posedge clk) begin
		if (sample_pop || event_pop) begin
			out_rec <= next_rec;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs

	assign log_valid = out_valid;
	assign log_data = out_rec;

endmodule

/* src/logger_macros.svh */
`ifndef LOGGER_MACROS_SVH
`define LOGGER_MACROS_SVH

////////////////////////////////////////////////////////////
// FIFO sizing

// Entries held by each channel FIFO
`define LOG_FIFO_DEPTH 8
// Address bits needed to index one FIFO memory
`define LOG_ADDR_BITS 3
// Fill level needs one more bit to count a full FIFO
`define LOG_LEVEL_BITS (`LOG_ADDR_BITS + 1)

////////////////////////////////////////////////////////////
// Payload field widths

`define LOG_SENSOR_ID_BITS 4
`define LOG_SAMPLE_VALUE_BITS 16
`define LOG_EVENT_CODE_BITS 8
// Data field of a log record fits a whole sample
`define LOG_DATA_BITS 20

`endif

/* src/logger_pkg.sv */
`include "logger_macros.svh"

package logger_pkg;

	////////////////////////////////////////////////////////////
	// Channel payloads

	// One sensor reading
	typedef struct packed {
		logic [`LOG_SENSOR_ID_BITS-1:0] sensor_id;
		logic [`LOG_SAMPLE_VALUE_BITS-1:0] value;
	} sample_t;

	// One discrete event
	typedef struct packed {
		logic [`LOG_EVENT_CODE_BITS-1:0] code;
	} event_t;

	////////////////////////////////////////////////////////////
	// Log output

	// Tag saying which channel a record came from
	typedef enum logic {
		SRC_SAMPLE = 1'b0,
		SRC_EVENT = 1'b1
	} log_source_e;

	// Tagged record on the shared log port
	// Samples sit in data as is, event codes are zero-extended
	typedef struct packed {
		log_source_e source;
		logic [`LOG_DATA_BITS-1:0] data;
	} log_record_t;

	////////////////////////////////////////////////////////////
	// Status

	// Words currently held in each FIFO
	typedef struct packed {
		logic [`LOG_LEVEL_BITS-1:0] sample_level;
		logic [`LOG_LEVEL_BITS-1:0] event_level;
	} fifo_status_t;

endpackage

/* src/memory_macro.sv */
module memory_macro #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8,
	localparam int ADDR_BITS = $clog2(DEPTH)
) (
	input logic clk,

	// Write port
	input logic wr_en,
	input logic [ADDR_BITS-1:0] wr_addr,
	input logic [WIDTH-1:0] wr_data,

	// Read port
	input logic [ADDR_BITS-1:0] rd_addr,
	output logic [WIDTH-1:0] rd_data
);

	////////////////////////////////////////////////////////////
	// Storage

	// Plain register array
	// Contents only matter once the FIFO pointers mark them valid
	logic [WIDTH-1:0] mem [DEPTH];

	////////////////////////////////////////////////////////////
	// Write port

	// Synchronous write on the rising edge
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Read port

	// Asynchronous read
	// Gives the FIFO its first-word-fall-through head
	always_comb begin
		rd_data = mem[rd_addr];
	end

endmodule

/* src/sync_fifo.sv */
module sync_fifo #(
	parameter type payload_t = logger_pkg::sample_t,
	// Must be a power of two for the wrapping pointers
	parameter int DEPTH = 8,
	localparam int ADDR_BITS = $clog2(DEPTH)
) (
	input logic clk,
	input logic reset,

	// Push side
	input logic wr,
	input payload_t din,

	// Pop side, head word shows while empty is low
	input logic rd,
	output payload_t dout,

	// Flags
	output logic empty,
	output logic full,

	// Words ready to read and spaces free to write
	output logic [ADDR_BITS:0] rsize,
	output logic [ADDR_BITS:0] wsize,

	// One-cycle error pulses
	output logic overflow,
	output logic underflow
);

	////////////////////////////////////////////////////////////
	// Pointers

	// Top bit is a lap counter
	// It tells a full FIFO from an empty one
	logic [ADDR_BITS:0] rpos;
	logic [ADDR_BITS:0] wpos;

	// Accepted operations
	logic do_write;
	logic do_read;

	// Same slot and same lap means nothing stored
	assign empty = (rpos == wpos);

	// Same slot but writer one lap ahead
	assign full = (wpos[ADDR_BITS-1:0] == rpos[ADDR_BITS-1:0]) &&
		(wpos[ADDR_BITS] != rpos[ADDR_BITS]);

	// Pointer difference wraps correctly in ADDR_BITS+1 bits
	assign rsize = wpos - rpos;
	assign wsize = (ADDR_BITS + 1)'(DEPTH) + rpos - wpos;

	// Writes are dropped when full, reads when empty
	assign do_write = wr && !full;
	assign do_read = rd && !empty;

	////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk) begin
		// Reset wins over any write or read in the same cycle
		if (reset) begin
			rpos <= '0;
			wpos <= '0;
			overflow <= 1'b0;
			underflow <= 1'b0;
		end else begin
			// Error pulses last one cycle
			overflow <= wr && full;
			underflow <= rd && empty;

			// Advance past the word just popped
			if (do_read) begin
				rpos <= rpos + 1'b1;
			end

			// Advance past the slot just written
			if (do_write) begin
				wpos <= wpos + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Storage

	// Write port follows wpos
	// Read port follows rpos, so dout is always the head
	memory_macro #(
		.WIDTH($bits(payload_t)),
		.DEPTH(DEPTH)
	) mem (
		.clk(clk),
		.wr_en(do_write),
		.wr_addr(wpos[ADDR_BITS-1:0]),
		.wr_data(din),
		.rd_addr(rpos[ADDR_BITS-1:0]),
		.rd_data(dout)
	);

endmodule

/* testbench/event_logger_assert.sv */
module event_logger_assert #(
	parameter int DATA_BITS = 1
) (
	input logic clk,
	input logic reset,

	// FIFO side
	input logic overflow,
	input logic underflow,
	input logic full,
	input logic empty,
	input logic pop,

	// Output register side
	input logic out_valid,
	input logic out_ready,
	input logic [DATA_BITS-1:0] out_data
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////////////////////////
	// FIFO health

	// Gated handshakes never write into a full FIFO
	no_overflow: assert property (@(posedge clk) disable iff (reset) !overflow)
		else $error("FIFO overflow pulse seen");

	// Pops are gated with empty
	no_underflow: assert property (@(posedge clk) disable iff (reset) !underflow)
		else $error("FIFO underflow pulse seen");

	flags_exclusive: assert property (@(posedge clk) disable iff (reset) !(full && empty))
		else $error("FIFO full and empty at once");

	// Arbiter only pops a FIFO that holds a word
	pop_needs_data: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else $error("pop issued to an empty FIFO");

	////////////////////////////////////////////////////////////
	// Output hold under back-pressure

	// A stalled record stays put until accepted
	hold_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("log record changed while stalled");

endmodule

/* testbench/event_logger_tb.sv */
`include "logger_macros.svh"

module event_logger_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import logger_pkg::*;

	localparam int DRIVE_DELAY = 2;
	localparam int DEPTH = `LOG_FIFO_DEPTH;

	// One row of the stimulus table
	typedef struct packed {
		bit s_valid;
		bit e_valid;
		bit log_ready;
		bit s_rand;
		bit e_rand;
		bit valid_rand;
		bit ready_rand;
		sample_t s_data;
		event_t e_data;
		int count;
	} step_t;

	logic clk;
	logic reset;
	logic sample_valid;
	logic sample_ready;
	sample_t sample_data;
	logic event_valid;
	logic event_ready;
	event_t event_data;
	logic log_valid;
	logic log_ready;
	log_record_t log_data;
	fifo_status_t status;

	// Stimulus table and reference state
	step_t table_steps[$];
	sample_t sample_q[$];
	event_t event_q[$];
	bit model_valid;
	log_record_t model_rec;
	log_source_e last_src;
	bit s_hold;
	bit e_hold;
	int in_count;
	int out_count;
	int cycle_count;
	int cycle_limit;

	tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) clock_gen (
		.clk(clk),
		.reset(reset)
	);

	event_logger_top dut (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.sample_data(sample_data),
		.event_valid(event_valid),
		.event_ready(event_ready),
		.event_data(event_data),
		.log_valid(log_valid),
		.log_ready(log_ready),
		.log_data(log_data),
		.status(status)
	);

	// Covers both FIFO instances
	bind sync_fifo event_logger_assert #(.DATA_BITS(1)) fifo_checks (
		.clk(clk), .reset(reset), .overflow(overflow), .underflow(underflow),
		.full(full), .empty(empty), .pop(rd),
		.out_valid(1'b0), .out_ready(1'b1), .out_data(1'b0)
	);

	bind log_arbiter event_logger_assert #(.DATA_BITS(`LOG_DATA_BITS + 1)) arb_checks (
		.clk(clk), .reset(reset), .overflow(1'b0), .underflow(1'b0),
		.full(1'b0), .empty(1'b0), .pop(1'b0),
		.out_valid(log_valid), .out_ready(log_ready), .out_data(log_data)
	);

	////////////////////////////////////////////////////////////
	// Expected records and compare tasks

	function automatic log_record_t sample_record(sample_t s);
		log_record_t r;
		r.source = SRC_SAMPLE;
		r.data = {s.sensor_id, s.value};
		return r;
	endfunction

	// Event code lands in the low bits, upper bits zero
	function automatic log_record_t event_record(event_t e);
		log_record_t r;
		r.source = SRC_EVENT;
		r.data = {{(`LOG_DATA_BITS - `LOG_EVENT_CODE_BITS){1'b0}}, e.code};
		return r;
	endfunction

	task automatic check_record(log_record_t got, log_record_t exp, string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got source %0d data %h, expected source %0d data %h",
				$time, what, got.source, got.data, exp.source, exp.data);
			$display("TEST FAIL");
			$fatal(1, "record mismatch");
		end
	endtask

	task automatic check_status(fifo_status_t got, fifo_status_t exp, string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got sample %0d event %0d, expected sample %0d event %0d",
				$time, what, got.sample_level, got.event_level,
				exp.sample_level, exp.event_level);
			$display("TEST FAIL");
			$fatal(1, "status mismatch");
		end
	endtask

	task automatic check_ready(bit got, bit exp, string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0b, expected %0b", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Table building

	task automatic add_step(bit s_valid, bit e_valid, bit ready, bit s_rand, bit e_rand,
		bit valid_rand, bit ready_rand, logic [19:0] s_word, logic [7:0] e_word, int count);
		step_t st;
		st.s_valid = s_valid;
		st.e_valid = e_valid;
		st.log_ready = ready;
		st.s_rand = s_rand;
		st.e_rand = e_rand;
		st.valid_rand = valid_rand;
		st.ready_rand = ready_rand;
		st.s_data = s_word;
		st.e_data = e_word;
		st.count = count;
		table_steps.push_back(st);
	endtask

	////////////////////////////////////////////////////////////
	// One clock cycle, entered and left at posedge plus drive delay

	task automatic apply_cycle(step_t st);
		fifo_status_t exp_status;
		bit s_acc;
		bit e_acc;
		bit can_load;
		bit take_s;
		bit take_e;
		// New offers only once the previous one went through
		if (!s_hold) begin
			sample_valid = st.s_valid && (!st.valid_rand || $urandom_range(3) != 0);
			sample_data = st.s_rand ? 20'($urandom) : st.s_data;
		end
		if (!e_hold) begin
			event_valid = st.e_valid && (!st.valid_rand || $urandom_range(3) != 0);
			event_data = st.e_rand ? 8'($urandom) : st.e_data;
		end
		log_ready = st.ready_rand ? ($urandom_range(1) == 1) : st.log_ready;

		// Mid-cycle, everything settled
		@(negedge clk);
		exp_status.sample_level = `LOG_LEVEL_BITS'(sample_q.size());
		exp_status.event_level = `LOG_LEVEL_BITS'(event_q.size());
		check_ready(sample_ready, sample_q.size() < DEPTH, "sample_ready");
		check_ready(event_ready, event_q.size() < DEPTH, "event_ready");
		check_status(status, exp_status, "fill levels");
		check_ready(log_valid, model_valid, "log_valid");
		if (model_valid) begin
			check_record(log_data, model_rec, "log_data");
		end

		// Transfers at the coming edge
		s_acc = sample_valid && sample_q.size() < DEPTH;
		e_acc = event_valid && event_q.size() < DEPTH;
		if (log_valid && log_ready) begin
			out_count++;
		end

		// Round robin, the source not served last wins a tie
		can_load = !model_valid || log_ready;
		take_s = can_load && sample_q.size() > 0 &&
			(event_q.size() == 0 || last_src == SRC_EVENT);
		take_e = can_load && !take_s && event_q.size() > 0;
		if (take_s) begin
			model_rec = sample_record(sample_q.pop_front());
			last_src = SRC_SAMPLE;
		end else if (take_e) begin
			model_rec = event_record(event_q.pop_front());
			last_src = SRC_EVENT;
		end
		if (can_load) begin
			model_valid = take_s || take_e;
		end

		// Pushes after pops, the head was already there
		if (s_acc) begin
			sample_q.push_back(sample_data);
			in_count++;
		end
		if (e_acc) begin
			event_q.push_back(event_data);
			in_count++;
		end
		s_hold = sample_valid && !s_acc;
		e_hold = event_valid && !e_acc;

		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	////////////////////////////////////////////////////////////
	// Timeout

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the log did not drain within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int total;
		step_t drain_step;
		sample_valid = 1'b0;
		sample_data = '0;
		event_valid = 1'b0;
		event_data = '0;
		log_ready = 1'b0;
		model_valid = 1'b0;
		model_rec = '0;
		last_src = SRC_EVENT;
		s_hold = 1'b0;
		e_hold = 1'b0;
		in_count = 0;
		out_count = 0;
		cycle_count = 0;
		cycle_limit = 0;
		void'($urandom(32'h8a40ae99));

		// Idle after reset
		add_step(0, 0, 1, 0, 0, 0, 0, 20'h0, 8'h00, 2);
		// Both channels at once, samples win the first contention after reset
		add_step(1, 1, 1, 0, 0, 0, 0, 20'hc1234, 8'h81, 1);
		add_step(0, 0, 1, 0, 0, 0, 0, 20'h0, 8'h00, 4);
		// Single records on each channel
		add_step(1, 0, 1, 0, 0, 0, 0, 20'h3beef, 8'h00, 1);
		add_step(0, 0, 1, 0, 0, 0, 0, 20'h0, 8'h00, 4);
		add_step(0, 1, 1, 0, 0, 0, 0, 20'h0, 8'ha5, 1);
		add_step(0, 0, 1, 0, 0, 0, 0, 20'h0, 8'h00, 4);
		// Fill both FIFOs behind a stalled consumer
		add_step(1, 1, 0, 1, 1, 0, 0, 20'h0, 8'h00, 12);
		add_step(0, 0, 0, 0, 0, 0, 0, 20'h0, 8'h00, 3);
		// Release both backlogs together
		add_step(0, 0, 1, 0, 0, 0, 0, 20'h0, 8'h00, 20);
		// Uneven backlogs, events run out first
		add_step(1, 1, 0, 1, 1, 0, 0, 20'h0, 8'h00, 3);
		add_step(1, 0, 0, 1, 0, 0, 0, 20'h0, 8'h00, 5);
		add_step(0, 0, 1, 0, 0, 0, 0, 20'h0, 8'h00, 20);
		// Random single-source streams with random back-pressure
		add_step(1, 0, 0, 1, 0, 1, 1, 20'h0, 8'h00, 60);
		add_step(0, 1, 0, 0, 1, 1, 1, 20'h0, 8'h00, 60);
		add_step(0, 0, 1, 0, 0, 0, 0, 20'h0, 8'h00, 20);

		total = 0;
		foreach (table_steps[i]) begin
			total += table_steps[i].count;
		end
		cycle_limit = 2 * total + 100;

		wait (reset == 1'b0);
		@(posedge clk);
		#DRIVE_DELAY;

		foreach (table_steps[i]) begin
			repeat (table_steps[i].count) apply_cycle(table_steps[i]);
		end

		// Drain whatever is still queued
		drain_step = '0;
		drain_step.log_ready = 1'b1;
		while (sample_q.size() > 0 || event_q.size() > 0 || model_valid || s_hold || e_hold) begin
			apply_cycle(drain_step);
		end

		@(negedge clk);
		check_status(status, '0, "final fill levels");
		check_ready(log_valid, 1'b0, "final log_valid");

		if (in_count != out_count) begin
			$display("accepted %0d words but logged %0d records", in_count, out_count);
			$display("TEST FAIL");
			$fatal(1, "word count mismatch");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// Free-running clock, low at time zero
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Synchronous reset, high over the first rising edges
	// Released a short delay after an edge like any other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset = 1'b0;
	end

endmodule
